/* rtl/decodePkg.sv */
// decode stage shared widths, encodings and lane bundles
package decodePkg;

    ////////////////////
    // widths and counts
    ////////////////////
    localparam int WORD_W    = 32;
    localparam int GPR_W     = 5;
    localparam int EXC_W     = 5;
    localparam int LANES     = 2;    // lane 0 upper, lane 1 lower
    localparam int PRODUCERS = 3;    // 0 mem, 1 upper exe, 2 lower exe

    localparam logic [EXC_W-1:0] EXC_RI = 5'd10;    // reserved instruction

    ////////////////////
    // encodings
    ////////////////////
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26
    } funct_t;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} extendMode_t;

    // bit p+1 picks producer p, bit 0 the register file, all zero means wait
    typedef logic [PRODUCERS:0] fwdSel_t;
    localparam fwdSel_t FWD_REGFILE = fwdSel_t'(1);

    ////////////////////
    // bundles
    ////////////////////
    typedef struct packed {
        logic [WORD_W-1:0] inst;
        logic [WORD_W-1:0] vAddr;
        logic              hasException;
        logic [EXC_W-1:0]  excCode;
    } laneIn_t;

    typedef struct packed {
        laneIn_t [LANES-1:0] lane;
        logic [1:0]          issueMode;   // bit 1 upper present, bit 0 lower present
    } issuePair_t;

    typedef struct packed {
        logic [GPR_W-1:0] writeNum;
        logic             ready;
    } producer_t;

    typedef struct packed {
        logic              we;
        logic [GPR_W-1:0]  num;
        logic [WORD_W-1:0] data;
    } wbPort_t;

    typedef struct packed {
        aluOp_t                 aluOp;
        logic [GPR_W-1:0]       writeNum;
        logic [1:0][WORD_W-1:0] readData;    // [0] rs, [1] rt
        logic [WORD_W-1:0]      operand0;
        logic [WORD_W-1:0]      operand1;
        logic                   operand0IsReg;
        logic                   operand1IsReg;
        fwdSel_t [1:0]          fwdSel;
        logic [WORD_W-1:0]      vAddr;
        logic                   hasException;
        logic [EXC_W-1:0]       excCode;
    } laneOut_t;

endpackage

/* rtl/issueStageReg.sv */
// stage register holding the instruction pair between issue queue and decode
`timescale 1ns/1ps

module issueStageReg (
    input  logic                  clk,
    input  logic                  reset_i,
    input  decodePkg::issuePair_t pair_i,
    input  logic                  update_i,
    input  logic                  clear_i,
    output decodePkg::issuePair_t pair_o
);
    import decodePkg::*;

    issuePair_t pairQ;

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            pairQ <= '0;             // empty stage
        end else if (update_i) begin
            pairQ <= pair_i;
        end
    end

    assign pair_o = pairQ;

    ////////////////////
    // checks
    ////////////////////

    // the top never asks to load and drop in the same cycle
    updateClearExclusive: assert property (
        @(posedge clk) disable iff (reset_i)
        !(update_i && clear_i)
    ) else $error("stage register update and clear together");

    // a load is only requested with at least one lane present
    loadedPairNotEmpty: assert property (
        @(posedge clk) disable iff (reset_i)
        update_i |=> (pair_o.issueMode != 2'b00)
    ) else $error("stage register loaded an empty pair");

endmodule

/* rtl/gprFile.sv */
// general purpose register file, four reads and two write-back ports
`timescale 1ns/1ps

module gprFile (
    input  logic                                                   clk,
    input  logic                                                   reset_i,
    input  logic [2*decodePkg::LANES-1:0][decodePkg::GPR_W-1:0]    readNum_i,
    output logic [2*decodePkg::LANES-1:0][decodePkg::WORD_W-1:0]   readData_o,
    input  decodePkg::wbPort_t                                     wbPort_i,
    input  decodePkg::wbPort_t                                     lateWbPort_i
);
    import decodePkg::*;

    logic [WORD_W-1:0] regs [1:31];    // r0 is not stored

    ////////////////////
    // write ports
    ////////////////////
    always_ff @(posedge clk) begin
        if (!reset_i) begin
            if (wbPort_i.we && wbPort_i.num != '0) begin
                regs[wbPort_i.num] <= wbPort_i.data;
            end
            // issued second so the late port wins a same-register collision
            if (lateWbPort_i.we && lateWbPort_i.num != '0) begin
                regs[lateWbPort_i.num] <= lateWbPort_i.data;
            end
        end
    end

    ////////////////////
    // read ports with write-through
    ////////////////////
    always_comb begin
        for (int i = 0; i < 2*LANES; i++) begin
            if (readNum_i[i] == '0) begin
                readData_o[i] = '0;
            end else if (lateWbPort_i.we && lateWbPort_i.num == readNum_i[i]) begin
                readData_o[i] = lateWbPort_i.data;
            end else if (wbPort_i.we && wbPort_i.num == readNum_i[i]) begin
                readData_o[i] = wbPort_i.data;
            end else begin
                readData_o[i] = regs[readNum_i[i]];
            end
        end
    end

    // a write aimed at r0 must still carry defined data from the back end
    noUnknownZeroWrite: assert property (
        @(posedge clk) disable iff (reset_i)
        !((wbPort_i.we && wbPort_i.num == '0 && $isunknown(wbPort_i.data)) ||
          (lateWbPort_i.we && lateWbPort_i.num == '0 && $isunknown(lateWbPort_i.data)))
    ) else $error("write to r0 with unknown data");

endmodule

/* rtl/instDecoder.sv */
// one-lane decoder for the ALU subset with immediate and shift operand build
`timescale 1ns/1ps

module instDecoder (
    input  logic [decodePkg::WORD_W-1:0]      inst_i,
    output decodePkg::aluOp_t                 aluOp_o,
    output logic [1:0][decodePkg::GPR_W-1:0]  readNum_o,     // [0] rs, [1] rt
    output logic [1:0]                        needRead_o,
    output logic [decodePkg::GPR_W-1:0]       writeNum_o,
    output logic [decodePkg::WORD_W-1:0]      operand0_o,
    output logic [decodePkg::WORD_W-1:0]      operand1_o,
    output logic                              operand0IsReg_o,
    output logic                              operand1IsReg_o,
    output logic                              reservedInst_o
);
    import decodePkg::*;

    opcode_t     opcode;
    funct_t      funct;
    extendMode_t extMode;
    logic [15:0] imm;

    assign opcode = opcode_t'(inst_i[31:26]);
    assign funct  = funct_t'(inst_i[5:0]);
    assign imm    = inst_i[15:0];

    assign readNum_o  = {inst_i[20:16], inst_i[25:21]};
    assign operand0_o = {{(WORD_W-5){1'b0}}, inst_i[10:6]};    // sa field

    always_comb begin
        aluOp_o         = ALU_NONE;
        writeNum_o      = '0;
        needRead_o      = 2'b00;
        operand0IsReg_o = 1'b0;
        operand1IsReg_o = 1'b0;
        extMode         = EXT_SIGN;
        reservedInst_o  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                writeNum_o      = inst_i[15:11];   // rd
                needRead_o      = 2'b11;
                operand0IsReg_o = 1'b1;
                operand1IsReg_o = 1'b1;
                case (funct)
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_XOR:  aluOp_o = ALU_XOR;
                    FN_SLL, FN_SRL: begin
                        aluOp_o         = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        needRead_o      = 2'b10;       // rt only, sa replaces rs
                        operand0IsReg_o = 1'b0;
                    end
                    default: begin
                        reservedInst_o  = 1'b1;
                        writeNum_o      = '0;
                        needRead_o      = 2'b00;
                        operand0IsReg_o = 1'b0;
                        operand1IsReg_o = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI: begin
                writeNum_o      = inst_i[20:16];   // rt
                needRead_o      = 2'b01;
                operand0IsReg_o = 1'b1;
                if (opcode == OP_ADDIU) begin
                    aluOp_o = ALU_ADD;
                end else begin
                    aluOp_o = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                    extMode = EXT_ZERO;
                end
            end
            OP_LUI: begin
                aluOp_o    = ALU_LUI;
                writeNum_o = inst_i[20:16];
                extMode    = EXT_UPPER;
            end
            default: reservedInst_o = 1'b1;
        endcase
    end

    // immediate extender
    always_comb begin
        case (extMode)
            EXT_ZERO:  operand1_o = {{(WORD_W-16){1'b0}}, imm};
            EXT_UPPER: operand1_o = {imm, {(WORD_W-16){1'b0}}};
            default:   operand1_o = {{(WORD_W-16){imm[15]}}, imm};
        endcase
    end

endmodule

/* rtl/forwardUnit.sv */
// forwarding source selection per operand and not-ready conflict detection
`timescale 1ns/1ps

module forwardUnit (
    input  logic [2*decodePkg::LANES-1:0][decodePkg::GPR_W-1:0] readNum_i,
    input  logic [2*decodePkg::LANES-1:0]                       needRead_i,
    input  decodePkg::producer_t [decodePkg::PRODUCERS-1:0]     producers_i,
    output decodePkg::fwdSel_t [2*decodePkg::LANES-1:0]         fwdSel_o,
    output logic                                                conflict_o
);
    import decodePkg::*;

    fwdSel_t [2*LANES-1:0] fwdWhich;
    fwdSel_t               readyMask;
    logic [2*LANES-1:0]    waitOp;

    // register file value is always ready
    always_comb begin
        readyMask[0] = 1'b1;
        for (int p = 0; p < PRODUCERS; p++) begin
            readyMask[p+1] = producers_i[p].ready;
        end
    end

    ////////////////////
    // per operand match
    ////////////////////
    always_comb begin
        for (int i = 0; i < 2*LANES; i++) begin
            fwdWhich[i] = FWD_REGFILE;
            // rising index so the lower execute lane overrides the rest
            for (int p = 0; p < PRODUCERS; p++) begin
                if (readNum_i[i] != '0 && producers_i[p].writeNum == readNum_i[i]) begin
                    fwdWhich[i]      = '0;
                    fwdWhich[i][p+1] = 1'b1;
                end
            end
            fwdSel_o[i] = fwdWhich[i] & readyMask;
            waitOp[i]   = needRead_i[i] && (fwdSel_o[i] == '0);
        end
    end

    assign conflict_o = |waitOp;

endmodule

/* rtl/decodeStage.sv */
// dual-issue decode and issue stage, ALU subset, with forwarding and interlock
`timescale 1ns/1ps

module decodeStage (
    input  logic                                             clk,
    input  logic                                             reset_i,
    input  decodePkg::issuePair_t                            pair_i,
    output logic                                             allowin_o,
    input  logic                                             downAllowin_i,
    input  logic                                             flush_i,
    input  logic                                             dangerous_i,
    input  decodePkg::producer_t [decodePkg::PRODUCERS-1:0]  producers_i,
    input  decodePkg::wbPort_t                               wbPort_i,
    input  decodePkg::wbPort_t                               lateWbPort_i,
    output decodePkg::laneOut_t                              upOut_o,
    output decodePkg::laneOut_t                              downOut_o,
    output logic                                             upValid_o,
    output logic                                             downValid_o
);
    import decodePkg::*;

    issuePair_t                     pairQ;
    logic                           update, clear, stall, conflict, outOk;
    logic [2*LANES-1:0][GPR_W-1:0]  readNum;
    logic [2*LANES-1:0]             decNeedRead, needRead;
    logic [2*LANES-1:0][WORD_W-1:0] readData;
    fwdSel_t [2*LANES-1:0]          fwdSel;
    aluOp_t                         aluOp [LANES];
    logic [LANES-1:0][GPR_W-1:0]    writeNum;
    logic [LANES-1:0][WORD_W-1:0]   operand0, operand1;
    logic [LANES-1:0]               operand0IsReg, operand1IsReg, reservedInst;
    laneOut_t [LANES-1:0]           laneOut;

    issueStageReg stageReg (
        .clk(clk), .reset_i(reset_i), .pair_i(pair_i),
        .update_i(update), .clear_i(clear), .pair_o(pairQ)
    );

    gprFile gprs (
        .clk(clk), .reset_i(reset_i), .readNum_i(readNum), .readData_o(readData),
        .wbPort_i(wbPort_i), .lateWbPort_i(lateWbPort_i)
    );

    for (genvar l = 0; l < LANES; l++) begin : gLane
        instDecoder decoder (
            .inst_i(pairQ.lane[l].inst), .aluOp_o(aluOp[l]),
            .readNum_o(readNum[2*l +: 2]), .needRead_o(decNeedRead[2*l +: 2]),
            .writeNum_o(writeNum[l]), .operand0_o(operand0[l]), .operand1_o(operand1[l]),
            .operand0IsReg_o(operand0IsReg[l]), .operand1IsReg_o(operand1IsReg[l]),
            .reservedInst_o(reservedInst[l])
        );
        // absent lane never waits on a producer
        assign needRead[2*l +: 2] = decNeedRead[2*l +: 2] & {2{pairQ.issueMode[LANES-1-l]}};
    end

    forwardUnit fwd (
        .readNum_i(readNum), .needRead_i(needRead), .producers_i(producers_i),
        .fwdSel_o(fwdSel), .conflict_o(conflict)
    );

    ////////////////////
    // lane outputs
    ////////////////////
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            laneOut[l].aluOp         = aluOp[l];
            laneOut[l].writeNum      = writeNum[l];
            laneOut[l].readData      = readData[2*l +: 2];
            laneOut[l].operand0      = operand0[l];
            laneOut[l].operand1      = operand1[l];
            laneOut[l].operand0IsReg = operand0IsReg[l];
            laneOut[l].operand1IsReg = operand1IsReg[l];
            laneOut[l].fwdSel        = fwdSel[2*l +: 2];
            laneOut[l].vAddr         = pairQ.lane[l].vAddr;
            laneOut[l].hasException  = pairQ.lane[l].hasException || reservedInst[l];
            laneOut[l].excCode       = pairQ.lane[l].hasException ? pairQ.lane[l].excCode
                                                                  : EXC_RI;
        end
    end

    assign upOut_o   = laneOut[0];
    assign downOut_o = laneOut[1];

    ////////////////////
    // interlock
    ////////////////////
    assign stall       = dangerous_i || conflict;
    assign allowin_o   = (pairQ.issueMode == 2'b00) || (downAllowin_i && !stall);
    assign outOk       = !stall && downAllowin_i && !flush_i;
    assign upValid_o   = pairQ.issueMode[1] && outOk;
    assign downValid_o = pairQ.issueMode[0] && outOk;
    assign update      = allowin_o && (pair_i.issueMode != 2'b00) && !flush_i;
    assign clear       = flush_i || (allowin_o && pair_i.issueMode == 2'b00);

endmodule

/* testbench/tbDecodeStage.sv */
// testbench for the dual-issue decode stage, directed tests with self-checks
`timescale 1ns/1ps

module tbDecodeStage;
    import decodePkg::*;

    localparam int MAX_CYCLES = 2000;    // tests take under 200 cycles

    // MIPS opcode and funct encodings
    localparam logic [5:0] ENC_ADDIU = 6'h09, ENC_ANDI = 6'h0c, ENC_ORI = 6'h0d;
    localparam logic [5:0] ENC_LUI = 6'h0f, ENC_SLL = 6'h00, ENC_SRL = 6'h02;
    localparam logic [5:0] ENC_ADDU = 6'h21, ENC_SUBU = 6'h23, ENC_AND = 6'h24;
    localparam logic [5:0] ENC_OR = 6'h25, ENC_XOR = 6'h26;

    logic                      clk;
    logic                      reset_i;
    issuePair_t                pair_i;
    logic                      allowin_o;
    logic                      downAllowin_i;
    logic                      flush_i;
    logic                      dangerous_i;
    producer_t [PRODUCERS-1:0] producers_i;    // [2] lower exe, [1] upper exe, [0] mem
    wbPort_t                   wbPort_i;
    wbPort_t                   lateWbPort_i;
    laneOut_t                  upOut_o;
    laneOut_t                  downOut_o;
    logic                      upValid_o;
    logic                      downValid_o;
    logic [WORD_W-1:0]         regModel [32];    // expected register contents
    int                        cycles = 0;

    decodeStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] rs, rt, rd, sa,
                                            input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs, rt,
                                            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic issuePair_t makePair(input logic [31:0] upInst, downInst,
                                            input logic [1:0] mode);
        issuePair_t p;
        p                = '0;
        p.lane[0].inst   = upInst;
        p.lane[0].vAddr  = $urandom;
        p.lane[1].inst   = downInst;
        p.lane[1].vAddr  = $urandom;
        p.issueMode      = mode;
        return p;
    endfunction

    // offer a pair, wait for allowin, then show it for one cycle
    task automatic sendPair(input issuePair_t p);
        @(posedge clk);
        pair_i <= p;
        @(negedge clk);
        while (!allowin_o) @(negedge clk);
        @(posedge clk);
        pair_i <= '0;
        @(negedge clk);
    endtask

    task automatic expectValids(input logic up, down, allow);
        checkValue("upValid_o", 32'(upValid_o), 32'(up));
        checkValue("downValid_o", 32'(downValid_o), 32'(down));
        checkValue("allowin_o", 32'(allowin_o), 32'(allow));
    endtask

    task automatic expectRegLane(input string tag, input laneOut_t o, input logic [31:0] inst,
                                 input aluOp_t op);
        checkValue({tag, ".aluOp"}, 32'(o.aluOp), 32'(op));
        checkValue({tag, ".writeNum"}, 32'(o.writeNum), 32'(inst[15:11]));
        checkValue({tag, ".readData[0]"}, o.readData[0], regModel[inst[25:21]]);
        checkValue({tag, ".readData[1]"}, o.readData[1], regModel[inst[20:16]]);
        checkValue({tag, ".fwdSel[0]"}, 32'(o.fwdSel[0]), 32'h1);
        checkValue({tag, ".fwdSel[1]"}, 32'(o.fwdSel[1]), 32'h1);
    endtask

    task automatic expectImmLane(input string tag, input laneOut_t o, input aluOp_t op,
                                 input logic [4:0] wnum, input logic [31:0] imm32,
                                 input logic op0Reg);
        checkValue({tag, ".aluOp"}, 32'(o.aluOp), 32'(op));
        checkValue({tag, ".writeNum"}, 32'(o.writeNum), 32'(wnum));
        checkValue({tag, ".operand1"}, o.operand1, imm32);
        checkValue({tag, ".operand0IsReg"}, 32'(o.operand0IsReg), 32'(op0Reg));
        checkValue({tag, ".operand1IsReg"}, 32'(o.operand1IsReg), 32'd0);
    endtask

    task automatic expectShiftLane(input string tag, input laneOut_t o, input aluOp_t op,
                                   input logic [31:0] inst);
        checkValue({tag, ".aluOp"}, 32'(o.aluOp), 32'(op));
        checkValue({tag, ".writeNum"}, 32'(o.writeNum), 32'(inst[15:11]));
        checkValue({tag, ".operand0"}, o.operand0, {27'h0, inst[10:6]});
        checkValue({tag, ".operand0IsReg"}, 32'(o.operand0IsReg), 32'd0);
        checkValue({tag, ".operand1IsReg"}, 32'(o.operand1IsReg), 32'd1);
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic resetState();
        expectValids(1'b0, 1'b0, 1'b1);
    endtask

    task automatic regReadback();
        logic [4:0]  rd;
        logic [31:0] upInst, downInst;
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            regModel[r] = $urandom;
            wbPort_i <= {1'b1, 5'(r), regModel[r]};
        end
        // both ports on one register, late port must win
        rd = 5'($urandom % 31 + 1);
        @(posedge clk);
        regModel[rd] = $urandom;
        wbPort_i     <= {1'b1, rd, ~regModel[rd]};
        lateWbPort_i <= {1'b1, rd, regModel[rd]};
        @(posedge clk);
        wbPort_i     <= '0;
        lateWbPort_i <= '0;
        for (int n = 0; n < 5; n++) begin
            upInst   = encodeR(5'($urandom), 5'($urandom), 5'($urandom), 5'd0, ENC_ADDU);
            downInst = encodeR(5'($urandom), 5'($urandom), 5'($urandom), 5'd0, ENC_SUBU);
            if (n == 0) begin
                upInst   = encodeR(5'd0, rd, 5'd1, 5'd0, ENC_ADDU);    // r0 and collision
                downInst = encodeR(rd, 5'd0, 5'd2, 5'd0, ENC_SUBU);
            end
            sendPair(makePair(upInst, downInst, 2'b11));
            expectValids(1'b1, 1'b1, 1'b1);
            expectRegLane("upOut_o", upOut_o, upInst, ALU_ADD);
            expectRegLane("downOut_o", downOut_o, downInst, ALU_SUB);
        end
    endtask

    task automatic operandBuild();
        logic [15:0] imm;
        logic [4:0]  rs, rt;
        logic [31:0] upInst, downInst;
        imm = 16'($urandom) | 16'h8000;    // negative, so sign and zero extension differ
        rs  = 5'($urandom);
        rt  = 5'($urandom);
        sendPair(makePair(encodeI(ENC_ADDIU, rs, rt, imm), encodeI(ENC_ANDI, rs, rt, imm),
                          2'b11));
        expectImmLane("upOut_o", upOut_o, ALU_ADD, rt, {{16{imm[15]}}, imm}, 1'b1);
        expectImmLane("downOut_o", downOut_o, ALU_AND, rt, {16'h0, imm}, 1'b1);
        sendPair(makePair(encodeI(ENC_ORI, rs, rt, imm), encodeI(ENC_LUI, 5'd0, rt, imm),
                          2'b11));
        expectImmLane("upOut_o", upOut_o, ALU_OR, rt, {16'h0, imm}, 1'b1);
        expectImmLane("downOut_o", downOut_o, ALU_LUI, rt, {imm, 16'h0}, 1'b0);
        upInst   = encodeR(5'd0, rt, rs, 5'($urandom), ENC_SLL);
        downInst = encodeR(5'd0, rs, rt, 5'($urandom), ENC_SRL);
        sendPair(makePair(upInst, downInst, 2'b11));
        expectShiftLane("upOut_o", upOut_o, ALU_SLL, upInst);
        expectShiftLane("downOut_o", downOut_o, ALU_SRL, downInst);
    endtask

    task automatic forwardStall();
        logic [4:0] r, q;
        issuePair_t p;
        r = 5'($urandom % 30 + 1);
        q = r + 5'd1;
        @(posedge clk);
        producers_i <= {{r, 1'b1}, {q, 1'b1}, {q, 1'b1}};
        sendPair(makePair(encodeR(r, q, 5'd3, 5'd0, ENC_ADDU),
                          encodeR(q, 5'd0, 5'd4, 5'd0, ENC_ADDU), 2'b11));
        expectValids(1'b1, 1'b1, 1'b1);
        checkValue("upOut_o.fwdSel[0]", 32'(upOut_o.fwdSel[0]), 32'h8);
        checkValue("upOut_o.fwdSel[1]", 32'(upOut_o.fwdSel[1]), 32'h4);    // upper beats mem
        checkValue("downOut_o.fwdSel[0]", 32'(downOut_o.fwdSel[0]), 32'h4);
        checkValue("downOut_o.fwdSel[1]", 32'(downOut_o.fwdSel[1]), 32'h1);
        // lower exe matches first but is not ready
        @(posedge clk);
        producers_i <= {{r, 1'b0}, {r, 1'b1}, {q, 1'b1}};
        p = makePair(encodeR(r, q, 5'd5, 5'd0, ENC_ADDU), encodeR(q, q, 5'd6, 5'd0, ENC_SUBU),
                     2'b11);
        sendPair(p);
        expectValids(1'b0, 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        expectValids(1'b0, 1'b0, 1'b0);
        checkValue("upOut_o.vAddr", upOut_o.vAddr, p.lane[0].vAddr);
        @(posedge clk);
        producers_i[2].ready <= 1'b1;
        @(negedge clk);
        expectValids(1'b1, 1'b1, 1'b1);
        checkValue("upOut_o.fwdSel[0]", 32'(upOut_o.fwdSel[0]), 32'h8);
        checkValue("upOut_o.fwdSel[1]", 32'(upOut_o.fwdSel[1]), 32'h2);
        checkValue("downOut_o.fwdSel[0]", 32'(downOut_o.fwdSel[0]), 32'h2);
        @(posedge clk);
        producers_i <= '0;
        dangerous_i <= 1'b1;
        sendPair(makePair(encodeR(r, q, 5'd7, 5'd0, ENC_XOR), encodeR(q, r, 5'd8, 5'd0, ENC_OR),
                          2'b11));
        expectValids(1'b0, 1'b0, 1'b0);
        @(posedge clk);
        dangerous_i <= 1'b0;
        @(negedge clk);
        expectValids(1'b1, 1'b1, 1'b1);
    endtask

    task automatic backpressureFlush();
        issuePair_t p;
        p = makePair(encodeR(5'd2, 5'd3, 5'd4, 5'd0, ENC_OR),
                     encodeI(ENC_ORI, 5'd5, 5'd6, 16'h00ff), 2'b11);
        @(posedge clk);
        downAllowin_i <= 1'b0;
        sendPair(p);
        expectValids(1'b0, 1'b0, 1'b0);
        repeat (2) @(negedge clk);
        expectValids(1'b0, 1'b0, 1'b0);
        checkValue("upOut_o.vAddr", upOut_o.vAddr, p.lane[0].vAddr);
        checkValue("downOut_o.vAddr", downOut_o.vAddr, p.lane[1].vAddr);
        @(posedge clk);
        downAllowin_i <= 1'b1;
        flush_i       <= 1'b1;
        pair_i        <= p;    // offered pair must not load under flush
        @(negedge clk);
        expectValids(1'b0, 1'b0, 1'b1);
        @(posedge clk);
        flush_i       <= 1'b0;
        downAllowin_i <= 1'b0;
        pair_i        <= '0;
        @(negedge clk);
        expectValids(1'b0, 1'b0, 1'b1);    // empty, so downstream block does not matter
        @(posedge clk);
        downAllowin_i <= 1'b1;
    endtask

    task automatic exceptionPass();
        issuePair_t p;
        logic [4:0] code;
        code = 5'($urandom % 10);    // anything but the RI code
        p = makePair(encodeI(6'h3f, 5'd1, 5'd2, 16'h1234),
                     encodeR(5'd1, 5'd2, 5'd3, 5'd0, ENC_AND), 2'b11);
        p.lane[1].hasException = 1'b1;
        p.lane[1].excCode      = code;
        sendPair(p);
        checkValue("upOut_o.hasException", 32'(upOut_o.hasException), 32'd1);
        checkValue("upOut_o.excCode", 32'(upOut_o.excCode), 32'd10);
        checkValue("upOut_o.aluOp", 32'(upOut_o.aluOp), 32'(ALU_NONE));
        checkValue("upOut_o.writeNum", 32'(upOut_o.writeNum), 32'd0);
        checkValue("downOut_o.hasException", 32'(downOut_o.hasException), 32'd1);
        checkValue("downOut_o.excCode", 32'(downOut_o.excCode), 32'(code));
        sendPair(makePair(encodeR(5'd1, 5'd2, 5'd3, 5'd0, ENC_XOR), 32'hffff_ffff, 2'b10));
        expectValids(1'b1, 1'b0, 1'b1);
        checkValue("upOut_o.hasException", 32'(upOut_o.hasException), 32'd0);
    endtask

    initial begin
        void'($urandom(32'hdb00));
        reset_i       = 1'b1;
        pair_i        = '0;
        downAllowin_i = 1'b1;
        flush_i       = 1'b0;
        dangerous_i   = 1'b0;
        producers_i   = '0;
        wbPort_i      = '0;
        lateWbPort_i  = '0;
        for (int r = 0; r < 32; r++) begin
            regModel[r] = '0;
        end
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        resetState();
        regReadback();
        operandBuild();
        forwardStall();
        backpressureFlush();
        exceptionPass();
        $display("TEST OK");
        $finish;
    end

endmodule

/* vlog.f */
rtl/decodePkg.sv
rtl/issueStageReg.sv
rtl/gprFile.sv
rtl/instDecoder.sv
rtl/forwardUnit.sv
rtl/decodeStage.sv
testbench/tbDecodeStage.sv

/* run.sh */
#!/bin/sh
# compile and run the decode stage testbench, exit status tells pass or fail
verilator --binary --timing --assert -f vlog.f --top-module tbDecodeStage -o simDecodeStage \
    && ./obj_dir/simDecodeStage \
    || exit 1
